/* verilog.f */
design/BranchPkg.sv
design/DecodeBus.sv
design/BranchDecode.sv
design/BranchResolve.sv
design/RedirectUnit.sv
design/BranchUnitTop.sv
tests/BranchUnitTb.sv

/* run.sh */
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and check the log.
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module BranchUnitTb -o simBranch \
    && ./obj_dir/simBranch > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/BranchUnitTb.sv */
// **************************************************
// Testbench for the branch unit top level.
// Clock, reset, directed and random stimulus,
// reference model, assertions and watchdog.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

module BranchUnitTb;

    localparam int numRandom  = 2000;
    // reset, directed cycles and drain, rounded up.
    localparam int numFixed   = 80;
    localparam int watchdogNs = (numRandom + numFixed) * 10 + 200;

    typedef struct packed {
        int          stamp;
        logic        taken;
        logic [31:0] target;
    } expItemT;

    logic             clk;
    logic             rstN;
    logic             instrValid;
    BranchPkg::wordT  instr;
    BranchPkg::addrT  pc;
    BranchPkg::wordT  rsVal;
    BranchPkg::wordT  rtVal;
    logic             redirect;
    BranchPkg::addrT  redirectPc;
    logic             resolveValid;
    logic             resolveTaken;

    // expected outputs, registered on the same edge as the DUT's.
    logic             expValid;
    logic             expTaken;
    logic             expRedirect;
    BranchPkg::addrT  expPc;
    expItemT          expQ[$];

    integer seed;
    int     errorCount;
    int     edgeCount;
    int     lastTaken;
    int     offeredCount;
    int     squashedCount;
    int     resolveCount;
    int     redirectCount;

    BranchUnitTop i_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .rsVal        (rsVal),
        .rtVal        (rtVal),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // **************************************************
    // stimulus helpers
    // **************************************************
    function automatic BranchPkg::wordT randWord();
        return $random(seed);
    endfunction

    // zero, negative, unit boundary or anything.
    function automatic BranchPkg::wordT pickOperand();
        BranchPkg::wordT r;
        r = randWord();
        case (r[1:0])
            2'd0:    return 32'd0;
            2'd1:    return randWord() | 32'h8000_0000;
            2'd2:    return r[2] ? 32'hFFFF_FFFF : 32'd1;
            default: return randWord();
        endcase
    endfunction

    function automatic BranchPkg::wordT encodeImm(input logic [5:0] op,
                                                  input logic [4:0] rtSel,
                                                  input logic [15:0] imm);
        return {op, 5'd3, rtSel, imm};
    endfunction

    function automatic BranchPkg::wordT encodeJump(input logic [25:0] index);
        return {BranchPkg::opJ, index};
    endfunction

    function automatic BranchPkg::wordT encodeJr();
        return {BranchPkg::opSpecial, 5'd5, 15'd0, BranchPkg::functJr};
    endfunction

    // lw, jal, add and an unused regimm selector.
    function automatic BranchPkg::wordT nonBranch(input BranchPkg::wordT f);
        case (f[27:26])
            2'd0:    return {6'h23, f[25:0]};
            2'd1:    return {6'h03, f[25:0]};
            2'd2:    return {BranchPkg::opSpecial, f[25:6], 6'h20};
            default: return {BranchPkg::opRegimm, f[25:21], f[20:16] | 5'b00010, f[15:0]};
        endcase
    endfunction

    task automatic offer(input logic v, input BranchPkg::wordT ins, input BranchPkg::addrT pcv,
                         input BranchPkg::wordT rs, input BranchPkg::wordT rt);
        @(posedge clk);
        instrValid <= v;
        instr      <= ins;
        pc         <= pcv;
        rsVal      <= rs;
        rtVal      <= rt;
    endtask

    task automatic idleCycle();
        offer(1'b0, 32'd0, 32'd0, 32'd0, 32'd0);
    endtask

    task automatic randomCycle();
        BranchPkg::wordT r;
        BranchPkg::wordT f;
        BranchPkg::wordT rs;
        BranchPkg::wordT rt;
        BranchPkg::wordT ins;
        int              pick;
        r    = randWord();
        f    = randWord();
        pick = int'(r[31:4] % 28'd10);
        rs   = pickOperand();
        rt   = r[3] ? rs : pickOperand();
        case (pick)
            // idle still carries a branch word, with valid low.
            0:       ins = encodeImm(BranchPkg::opBeq, 5'd2, f[15:0]);
            1:       ins = nonBranch(f);
            2:       ins = encodeImm(BranchPkg::opBeq, 5'd2, f[15:0]);
            3:       ins = encodeImm(BranchPkg::opBne, 5'd2, f[15:0]);
            4:       ins = encodeImm(BranchPkg::opRegimm, BranchPkg::rtBgez, f[15:0]);
            5:       ins = encodeImm(BranchPkg::opRegimm, BranchPkg::rtBltz, f[15:0]);
            6:       ins = encodeImm(BranchPkg::opBgtz, 5'd0, f[15:0]);
            7:       ins = encodeImm(BranchPkg::opBlez, 5'd0, f[15:0]);
            8:       ins = encodeJump(f[25:0]);
            default: ins = encodeJr();
        endcase
        offer(pick != 0, ins, randWord() & 32'hFFFF_FFFC, rs, rt);
    endtask

    // **************************************************
    // reference model
    // **************************************************
    task automatic modelInstr(input BranchPkg::wordT ins, input BranchPkg::addrT pcIn,
                              input BranchPkg::wordT rs, input BranchPkg::wordT rt,
                              output logic isBr, output logic tk, output BranchPkg::addrT tgt);
        BranchPkg::addrT    next;
        logic signed [31:0] a;
        next = pcIn + 32'd4;
        a    = rs;
        isBr = 1'b1;
        tk   = 1'b0;
        tgt  = next + {{14{ins[15]}}, ins[15:0], 2'b00};
        case (ins[31:26])
            BranchPkg::opSpecial: begin
                isBr = (ins[5:0] == BranchPkg::functJr);
                tk   = 1'b1;
                tgt  = rs;
            end
            BranchPkg::opRegimm: begin
                isBr = (ins[20:16] == BranchPkg::rtBltz) || (ins[20:16] == BranchPkg::rtBgez);
                tk   = (ins[20:16] == BranchPkg::rtBltz) ? (a < 0) : (a >= 0);
            end
            BranchPkg::opJ: begin
                tk  = 1'b1;
                tgt = {next[31:28], ins[25:0], 2'b00};
            end
            BranchPkg::opBeq:  tk = (rs == rt);
            BranchPkg::opBne:  tk = (rs != rt);
            BranchPkg::opBlez: tk = (a <= 0);
            BranchPkg::opBgtz: tk = (a > 0);
            default:           isBr = 1'b0;
        endcase
    endtask

    always @(posedge clk or negedge rstN) begin : refModel
        logic            isBr;
        logic            tk;
        BranchPkg::addrT tgt;
        expItemT         item;
        if (!rstN) begin
            edgeCount   = 0;
            lastTaken   = -100;
            expQ.delete();
            expValid    <= 1'b0;
            expTaken    <= 1'b0;
            expRedirect <= 1'b0;
            expPc       <= 32'd0;
        end else begin
            edgeCount = edgeCount + 1;
            if (expQ.size() != 0 && expQ[0].stamp == edgeCount) begin
                item        = expQ.pop_front();
                expValid    <= 1'b1;
                expTaken    <= item.taken;
                expRedirect <= item.taken;
                if (item.taken) begin
                    expPc <= item.target;
                end
            end else begin
                expValid    <= 1'b0;
                expTaken    <= 1'b0;
                expRedirect <= 1'b0;
            end
            if (instrValid) begin
                modelInstr(instr, pc, rsVal, rtVal, isBr, tk, tgt);
                if (isBr && edgeCount > lastTaken + BranchPkg::flushShadow) begin
                    item.stamp  = edgeCount + 2;
                    item.taken  = tk;
                    item.target = tgt;
                    expQ.push_back(item);
                    offeredCount = offeredCount + 1;
                    if (tk) begin
                        lastTaken = edgeCount;
                    end
                end else if (isBr) begin
                    squashedCount = squashedCount + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstN && resolveValid) begin
            resolveCount = resolveCount + 1;
        end
        if (rstN && redirect) begin
            redirectCount = redirectCount + 1;
        end
    end

    // **************************************************
    // checks
    // **************************************************
    aValid: assert property (@(posedge clk) disable iff (!rstN) resolveValid == expValid)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: resolveValid %0b, expected %0b", $time,
                     $sampled(resolveValid), $sampled(expValid));
        end

    aTaken: assert property (@(posedge clk) disable iff (!rstN) resolveTaken == expTaken)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: resolveTaken %0b, expected %0b", $time,
                     $sampled(resolveTaken), $sampled(expTaken));
        end

    aRedirect: assert property (@(posedge clk) disable iff (!rstN) redirect == expRedirect)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: redirect %0b, expected %0b", $time,
                     $sampled(redirect), $sampled(expRedirect));
        end

    aRedirectPc: assert property (@(posedge clk) disable iff (!rstN) redirectPc == expPc)
        else begin
            errorCount = errorCount + 1;
            $display("MISMATCH at %0t: redirectPc %h, expected %h", $time,
                     $sampled(redirectPc), $sampled(expPc));
        end

    initial begin
        #(watchdogNs);
        $display("timeout: the run did not finish within %0d ns", watchdogNs);
        $display("*** FAILED ***");
        $finish;
    end

    // **************************************************
    // main sequence
    // **************************************************
    initial begin
        seed          = 32'hafc9;
        errorCount    = 0;
        offeredCount  = 0;
        squashedCount = 0;
        resolveCount  = 0;
        redirectCount = 0;
        rstN          = 1'b0;
        instrValid    = 1'b0;
        instr         = 32'd0;
        pc            = 32'd0;
        rsVal         = 32'd0;
        rtVal         = 32'd0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;

        // quiet after reset, a branch word held with valid low.
        repeat (10) offer(1'b0, encodeImm(BranchPkg::opBeq, 5'd1, 16'd4), 32'h100, 0, 0);

        // not taken on every cycle, around the zero and sign boundaries.
        offer(1'b1, encodeImm(BranchPkg::opBne, 5'd2, 16'd8), 32'h200, 32'd5, 32'd5);
        offer(1'b1, encodeImm(BranchPkg::opBeq, 5'd2, 16'd8), 32'h204, 32'd1, 32'd2);
        offer(1'b1, encodeImm(BranchPkg::opBgtz, 5'd0, 16'd8), 32'h208, 32'd0, 32'd0);
        offer(1'b1, encodeImm(BranchPkg::opRegimm, BranchPkg::rtBltz, 16'd8), 32'h20c, 0, 0);
        offer(1'b1, encodeImm(BranchPkg::opRegimm, BranchPkg::rtBgez, 16'd8), 32'h210,
              32'hFFFF_FFFF, 0);
        offer(1'b1, encodeImm(BranchPkg::opBlez, 5'd0, 16'd8), 32'h214, 32'd1, 0);
        offer(1'b1, encodeImm(BranchPkg::opBgtz, 5'd0, 16'd8), 32'h218, 32'h8000_0000, 0);
        offer(1'b1, encodeImm(BranchPkg::opRegimm, BranchPkg::rtBltz, 16'd8), 32'h21c,
              32'h7FFF_FFFF, 0);

        // jump, three squashed inputs, then a taken backward branch.
        offer(1'b1, encodeJump(26'h155_5555), 32'h3000_0FFC, 0, 0);
        repeat (3) offer(1'b1, encodeImm(BranchPkg::opBeq, 5'd2, 16'd4), 32'h400, 9, 9);
        offer(1'b1, encodeImm(BranchPkg::opBeq, 5'd2, 16'hFFF0), 32'h500, 32'd9, 32'd9);
        repeat (3) idleCycle();

        // register jump, then taken compares against zero.
        offer(1'b1, encodeJr(), 32'h600, 32'h0040_1234, 0);
        repeat (3) offer(1'b1, encodeImm(BranchPkg::opBne, 5'd2, 16'd4), 32'h700, 1, 2);
        offer(1'b1, encodeImm(BranchPkg::opBlez, 5'd0, 16'd12), 32'h800, 32'd0, 0);
        repeat (3) idleCycle();
        offer(1'b1, encodeImm(BranchPkg::opRegimm, BranchPkg::rtBltz, 16'h8000), 32'h900,
              32'hFFFF_FFFF, 0);
        repeat (4) idleCycle();

        repeat (numRandom) randomCycle();
        repeat (8) idleCycle();

        if (expQ.size() != 0) begin
            errorCount = errorCount + 1;
            $display("expected resolutions were still pending when the run ended");
        end
        if (redirectCount == 0) begin
            errorCount = errorCount + 1;
            $display("no taken branch reached the redirect output");
        end
        $display("summary: %0d errors, %0d accepted, %0d squashed, %0d resolved, %0d redirects",
                 errorCount, offeredCount, squashedCount, resolveCount, redirectCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/BranchUnitTop.sv */
// **************************************************
// Top level of the branch path.
// Decode, execute and result stages on plain ports.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

module BranchUnitTop (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             instrValid,
    input  wire BranchPkg::wordT  instr,
    input  wire BranchPkg::addrT  pc,
    input  wire BranchPkg::wordT  rsVal,
    input  wire BranchPkg::wordT  rtVal,
    output      logic             redirect,
    output      BranchPkg::addrT  redirectPc,
    output      logic             resolveValid,
    output      logic             resolveTaken
);

    logic             flush;
    logic             exValid;
    logic             exTaken;
    BranchPkg::addrT  exTarget;

    DecodeBus decBus ();

    BranchDecode iDecode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .rsVal      (rsVal),
        .rtVal      (rtVal),
        .flush      (flush),
        .dec        (decBus.producer)
    );

    BranchResolve iResolve (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (decBus.consumer),
        .flush    (flush),
        .exValid  (exValid),
        .exTaken  (exTaken),
        .exTarget (exTarget)
    );

    RedirectUnit iRedirect (
        .clk          (clk),
        .rstN         (rstN),
        .exValid      (exValid),
        .exTaken      (exTaken),
        .exTarget     (exTarget),
        .flush        (flush),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken)
    );

endmodule

`default_nettype wire

/* design/RedirectUnit.sv */
// **************************************************
// Result stage of the branch path.
// Registers the redirect pulse and its pc,
// reports resolutions and drives flush.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

module RedirectUnit (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             exValid,
    input  wire logic             exTaken,
    input  wire BranchPkg::addrT  exTarget,
    output      logic             flush,
    output      logic             redirect,
    output      BranchPkg::addrT  redirectPc,
    output      logic             resolveValid,
    output      logic             resolveTaken
);

    logic accept;

    // the item right behind a redirect is dropped.
    assign accept = exValid && !redirect;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            redirect     <= 1'b0;
            resolveValid <= 1'b0;
            resolveTaken <= 1'b0;
            redirectPc   <= '0;
        end else begin
            resolveValid <= accept;
            resolveTaken <= accept && exTaken;
            redirect     <= accept && exTaken;
            if (accept && exTaken) begin
                redirectPc <= exTarget;
            end
        end
    end

    // one-cycle flush to the earlier stages.
    assign flush = redirect;

    // **************************************************
    // checks
    // **************************************************
    // the whole shadow stays quiet, so no redirect can follow.
    aRedirectShadow: assert property (
        @(posedge clk) disable iff (!rstN)
        redirect |=> (!redirect) [*BranchPkg::flushShadow]
    ) else $error("redirect inside the flush shadow");

    aRedirectReported: assert property (
        @(posedge clk) disable iff (!rstN)
        redirect |-> (resolveValid && resolveTaken)
    ) else $error("redirect without a taken resolution");

endmodule

`default_nettype wire

/* design/BranchResolve.sv */
// **************************************************
// Execute stage of the branch path.
// Evaluates the branch condition and registers
// the taken flag and target.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

module BranchResolve (
    input  wire logic             clk,
    input  wire logic             rstN,
    DecodeBus.consumer            dec,
    input  wire logic             flush,
    output      logic             exValid,
    output      logic             exTaken,
    output      BranchPkg::addrT  exTarget
);

    logic signed [BranchPkg::wordW-1:0] opASigned;
    logic                               taken;

    assign opASigned = dec.opA;

    // **************************************************
    // condition
    // **************************************************
    always_comb begin
        unique case (dec.code)
            BranchPkg::codeBeq:  taken = (dec.opA == dec.opB);
            BranchPkg::codeBne:  taken = (dec.opA != dec.opB);
            // signed compares against zero.
            BranchPkg::codeBgez: taken = (opASigned >= 0);
            BranchPkg::codeBgtz: taken = (opASigned > 0);
            BranchPkg::codeBlez: taken = (opASigned <= 0);
            BranchPkg::codeBltz: taken = (opASigned < 0);
            // jumps always go.
            BranchPkg::codeJr:   taken = 1'b1;
            BranchPkg::codeJ:    taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    // **************************************************
    // execute register
    // **************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= dec.valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            exTaken  <= taken;
            exTarget <= dec.target;
        end
    end

    // the item behind a redirect is squashed here.
    aFlushClearsEx: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> !exValid
    ) else $error("execute item survived a flush");

endmodule

`default_nettype wire

/* design/BranchDecode.sv */
// **************************************************
// Decode stage of the branch path.
// Classifies the instruction, builds the target
// and registers the item onto the decode bus.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

module BranchDecode (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             instrValid,
    input  wire BranchPkg::wordT  instr,
    input  wire BranchPkg::addrT  pc,
    input  wire BranchPkg::wordT  rsVal,
    input  wire BranchPkg::wordT  rtVal,
    input  wire logic             flush,
    DecodeBus.producer            dec
);

    logic [5:0]       opcode;
    logic [4:0]       rtField;
    logic [5:0]       funct;
    logic [15:0]      imm;
    logic [25:0]      index;
    BranchPkg::addrT  pcPlus4;
    BranchPkg::addrT  brTarget;
    BranchPkg::addrT  jTarget;
    BranchPkg::codeT  code;
    BranchPkg::addrT  target;
    logic             isBranch;

    assign opcode  = instr[31:26];
    assign rtField = instr[20:16];
    assign funct   = instr[5:0];
    assign imm     = instr[15:0];
    assign index   = instr[25:0];

    // **************************************************
    // target computation
    // **************************************************
    assign pcPlus4  = pc + 32'd4;
    assign brTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    // region of the next pc joined to the word index.
    assign jTarget  = {pcPlus4[31:28], index, 2'b00};

    // **************************************************
    // classification
    // **************************************************
    always_comb begin
        code = BranchPkg::codeNone;
        unique case (opcode)
            BranchPkg::opSpecial: begin
                if (funct == BranchPkg::functJr) begin
                    code = BranchPkg::codeJr;
                end
            end
            BranchPkg::opRegimm: begin
                if (rtField == BranchPkg::rtBltz) begin
                    code = BranchPkg::codeBltz;
                end else if (rtField == BranchPkg::rtBgez) begin
                    code = BranchPkg::codeBgez;
                end
            end
            BranchPkg::opJ:    code = BranchPkg::codeJ;
            BranchPkg::opBeq:  code = BranchPkg::codeBeq;
            BranchPkg::opBne:  code = BranchPkg::codeBne;
            BranchPkg::opBlez: code = BranchPkg::codeBlez;
            BranchPkg::opBgtz: code = BranchPkg::codeBgtz;
            default:           code = BranchPkg::codeNone;
        endcase
    end

    assign isBranch = (code != BranchPkg::codeNone);

    always_comb begin
        if (code == BranchPkg::codeJ) begin
            target = jTarget;
        end else if (code == BranchPkg::codeJr) begin
            target = rsVal;
        end else begin
            target = brTarget;
        end
    end

    // **************************************************
    // decode register
    // **************************************************
    // nothing is taken in while a redirect is out.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instrValid && isBranch && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid && isBranch) begin
            dec.code   <= code;
            dec.opA    <= rsVal;
            dec.opB    <= rtVal;
            dec.target <= target;
        end
    end

endmodule

`default_nettype wire

/* design/DecodeBus.sv */
// **************************************************
// Decode to execute bundle for one branch item.
// **************************************************
`timescale 1ns/100ps
`default_nettype none

interface DecodeBus;

    // strobe, the item counts whenever valid is high.
    logic              valid;
    BranchPkg::codeT   code;
    // first and second register operands.
    BranchPkg::wordT   opA;
    BranchPkg::wordT   opB;
    // taken target computed in decode.
    BranchPkg::addrT   target;

    modport producer (
        output valid,
        output code,
        output opA,
        output opB,
        output target
    );

    modport consumer (
        input valid,
        input code,
        input opA,
        input opB,
        input target
    );

endinterface

`default_nettype wire

/* design/BranchPkg.sv */
// **************************************************
// Shared widths, types and branch codes.
// MIPS opcode, REGIMM and funct field values.
// Squash depth after a taken branch.
// **************************************************
`default_nettype none

package BranchPkg;

    // **************************************************
    // widths and types
    // **************************************************
    localparam int wordW = 32;
    localparam int addrW = 32;
    localparam int codeW = 4;

    // data word, used for operands and the instruction.
    typedef logic [wordW-1:0] wordT;
    // program counter or branch target.
    typedef logic [addrW-1:0] addrT;
    // decoded branch kind.
    typedef logic [codeW-1:0] codeT;

    // **************************************************
    // branch codes
    // **************************************************
    localparam codeT codeNone = 4'd0;
    localparam codeT codeBeq  = 4'd1;
    localparam codeT codeBne  = 4'd2;
    localparam codeT codeBgez = 4'd3;
    localparam codeT codeBgtz = 4'd4;
    localparam codeT codeBlez = 4'd5;
    localparam codeT codeBltz = 4'd6;
    localparam codeT codeJr   = 4'd7;
    localparam codeT codeJ    = 4'd8;

    // **************************************************
    // instruction fields
    // **************************************************
    // primary opcodes, instr[31:26].
    localparam logic [5:0] opSpecial = 6'd0;
    localparam logic [5:0] opRegimm  = 6'd1;
    localparam logic [5:0] opJ       = 6'd2;
    localparam logic [5:0] opBeq     = 6'd4;
    localparam logic [5:0] opBne     = 6'd5;
    localparam logic [5:0] opBlez    = 6'd6;
    localparam logic [5:0] opBgtz    = 6'd7;

    // funct of JR under SPECIAL.
    localparam logic [5:0] functJr = 6'd8;

    // rt selectors under REGIMM.
    localparam logic [4:0] rtBltz = 5'd0;
    localparam logic [4:0] rtBgez = 5'd1;

    // input cycles squashed after a taken item's own input cycle.
    localparam int flushShadow = 3;

endpackage

`default_nettype wire
